/* Makefile */
# Verilator build and run of the ADXL355 logger testbench
TOP := adxl_logger_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* src.f */
src/sync_pkg.sv
src/adxl_pkg.sv
src/pps_decoder.sv
src/sync_nco.sv
src/adxl_spi_reader.sv
src/sample_collector.sv
src/adxl_logger_top.sv
testbench/tb_clock_gen.sv
testbench/adxl_spi_model.sv
testbench/adxl_logger_tb.sv

/* src/adxl_logger_top.sv */
// ADXL355 logger core: PPS decode, PPS-locked SYNC/DRDY, SPI burst read
// pps and adxl_miso are synchronized inside, faster/slower must be synchronous to clk
// clk_hz/pps_hz must stay below 2^22 and sync_hz/pps_hz below 4096
// sensor is expected in external sync mode with drdy wired to its SYNC pin
module adxl_logger_top #(
  parameter int clk_hz   = 40_000_000,
  parameter int pps_hz   = 10,
  parameter int pps_tol  = 20_000,  // 500 us at 40 MHz
  parameter int sync_hz  = 1000,
  parameter int pa_bits  = 30,
  parameter int sclk_div = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pps,
  input  logic                   faster,
  input  logic                   slower,
  input  logic                   adxl_miso,
  output logic                   adxl_csn,
  output logic                   adxl_sclk,
  output logic                   adxl_mosi,
  output logic                   drdy,
  output sync_pkg::sync_status_t status,
  output adxl_pkg::sample_t      sample,
  output logic                   sample_valid
);
  import sync_pkg::*;
  import adxl_pkg::*;

  pps_event_t pps_event;  // decoder to NCO
  logic       sync_tick;  // starts one burst
  adxl_byte_t rx_byte;    // reader to collector

  pps_decoder #(
    .clk_hz (clk_hz),
    .pps_hz (pps_hz),
    .pps_tol(pps_tol)
  ) pps_decoder_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pps      (pps),
    .pps_event(pps_event)
  );

  sync_nco #(
    .clk_hz (clk_hz),
    .pps_hz (pps_hz),
    .sync_hz(sync_hz),
    .pa_bits(pa_bits)
  ) sync_nco_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pps_event(pps_event),
    .faster   (faster),
    .slower   (slower),
    .sync_tick(sync_tick),
    .drdy     (drdy),
    .status   (status)
  );

  adxl_spi_reader #(
    .sclk_div(sclk_div)
  ) adxl_spi_reader_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .sync_tick(sync_tick),
    .miso     (adxl_miso),
    .csn      (adxl_csn),
    .sclk     (adxl_sclk),
    .mosi     (adxl_mosi),
    .rx_byte  (rx_byte)
  );

  sample_collector sample_collector_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_byte     (rx_byte),
    .sample      (sample),
    .sample_valid(sample_valid)
  );

endmodule

/* src/adxl_pkg.sv */
// ADXL355 register constants and data types for the burst reader
// burst covers XDATA3..ZDATA1 only, temperature and FIFO are not read
// axes are 20-bit two's complement, left aligned in each 3-byte group
package adxl_pkg;

  localparam logic [7:0] xdata3_addr = 8'h08;  // first data register
  localparam int         burst_len   = 9;      // XDATA3..ZDATA1

  // byte event from the SPI reader
  typedef struct packed {
    logic       strobe;  // single cycle
    logic [3:0] index;   // 0 is XDATA3
    logic [7:0] data;
  } adxl_byte_t;

  typedef logic signed [19:0] axis_t;

  // one assembled reading
  typedef struct packed {
    axis_t       x;
    axis_t       y;
    axis_t       z;
    logic [15:0] seq;  // wraps at 65535
  } sample_t;

endpackage

/* src/adxl_spi_reader.sv */
// SPI mode 0 burst reader for the ADXL355 data registers
// one burst per sync_tick, ticks that arrive mid-burst are dropped
// SCLK half period is sclk_div clocks, sclk_div must be 2 or more
// miso is taken at the end of the high phase so the synchronizer
// latency stays inside the half period
module adxl_spi_reader #(
  parameter int sclk_div = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sync_tick,
  input  logic                 miso,
  output logic                 csn,
  output logic                 sclk,
  output logic                 mosi,
  output adxl_pkg::adxl_byte_t rx_byte
);
  import adxl_pkg::*;

  localparam int total_bits = 8 * (burst_len + 1);  // command plus data
  localparam int bit_w      = $clog2(total_bits);
  localparam int div_w      = (sclk_div > 1) ? $clog2(sclk_div) : 1;
  localparam logic [7:0]       cmd      = {xdata3_addr[6:0], 1'b1};  // addr << 1, read
  localparam logic [div_w-1:0] div_last = div_w'(sclk_div - 1);
  localparam logic [bit_w-1:0] bit_last = bit_w'(total_bits - 1);

  logic [1:0]       miso_sync;
  logic             busy;
  logic             done;      // last falling edge issued
  logic [div_w-1:0] div_cnt;   // clocks within half period
  logic [bit_w-1:0] bit_cnt;   // bit of burst, command first
  logic [7:0]       tx_shift;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_next;
  logic             half_end;

  assign half_end = busy & ~done & (div_cnt == div_last);
  assign rx_next  = {rx_shift[6:0], miso_sync[1]};  // MSB first

  always_ff @(posedge clk)
  begin
    miso_sync <= {miso_sync[0], miso};
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      done    <= 1'b0;
      csn     <= 1'b1;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      rx_byte <= '0;
    end
    else
    begin
      rx_byte.strobe <= 1'b0;
      if (!busy)
      begin
        if (sync_tick)
        begin
          busy     <= 1'b1;
          csn      <= 1'b0;
          mosi     <= cmd[7];                  // first bit set up before first rise
          tx_shift <= {cmd[6:0], 1'b0};
          div_cnt  <= '0;
          bit_cnt  <= '0;
        end
      end
      else if (done)
      begin
        busy <= 1'b0;                          // csn up one cycle after last fall
        done <= 1'b0;
        csn  <= 1'b1;
        mosi <= 1'b0;
      end
      else
      begin
        div_cnt <= half_end ? '0 : div_cnt + 1'b1;
        if (half_end)
        begin
          sclk <= ~sclk;
          if (sclk)                            // falling edge
          begin
            rx_shift <= rx_next;
            mosi     <= tx_shift[7];           // zeros after the command
            tx_shift <= {tx_shift[6:0], 1'b0};
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt[2:0] == 3'd7 && bit_cnt[bit_w-1:3] != '0)
            begin
              rx_byte.strobe <= 1'b1;
              rx_byte.index  <= 4'(bit_cnt[bit_w-1:3] - 1'b1);  // skip command byte
              rx_byte.data   <= rx_next;
            end
            if (bit_cnt == bit_last)
              done <= 1'b1;
          end
        end
      end
    end
  end

endmodule

/* src/pps_decoder.sv */
// PPS input decoder with interval check
// pps is asynchronous, it passes a two-flop synchronizer
// event strobe lags the pps rising edge by 3 cycles
// first edge after reset has no reference and is always reported invalid
// clk_hz/pps_hz + pps_tol must fit the 22-bit interval field
module pps_decoder #(
  parameter int clk_hz  = 40_000_000,
  parameter int pps_hz  = 10,
  parameter int pps_tol = 20_000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pps,
  output sync_pkg::pps_event_t pps_event
);
  import sync_pkg::*;

  localparam int nominal = clk_hz / pps_hz;  // expected clocks per pulse
  localparam int lo_int  = (nominal > pps_tol) ? nominal - pps_tol : 0;
  localparam logic [interval_w-1:0] lo_lim = interval_w'(lo_int);
  localparam logic [interval_w-1:0] hi_lim = interval_w'(nominal + pps_tol);

  logic [2:0]            pps_sync;  // [1:0] synchronizer, [2] edge history
  logic                  rise;
  logic [interval_w-1:0] cnt;       // clocks since last edge
  logic [interval_w-1:0] meas;
  logic                  have_ref;  // an earlier edge was seen

  assign rise = pps_sync[1] & ~pps_sync[2];
  // count includes the edge cycle itself, saturates when pps is lost
  assign meas = (cnt == '1) ? cnt : cnt + 1'b1;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pps_sync  <= '0;
      cnt       <= '0;
      have_ref  <= 1'b0;
      pps_event <= '0;
    end
    else
    begin
      pps_sync         <= {pps_sync[1:0], pps};
      pps_event.strobe <= rise;  // edge register
      if (rise)
      begin
        cnt                <= '0;
        have_ref           <= 1'b1;
        pps_event.interval <= meas;
        // window check, only once a reference edge exists
        pps_event.valid    <= have_ref && (meas >= lo_lim) && (meas <= hi_lim);
      end
      else if (cnt != '1)
        cnt <= cnt + 1'b1;  // hold at max
    end
  end

endmodule

/* src/sample_collector.sv */
// assembles ADXL355 burst bytes into one three-axis sample
// bytes are placed by index, the last index (ZDATA1) publishes
// a burst cut short leaves stale bytes from the previous frame
module sample_collector (
  input  logic                 clk,
  input  logic                 rst_n,
  input  adxl_pkg::adxl_byte_t rx_byte,
  output adxl_pkg::sample_t    sample,
  output logic                 sample_valid
);
  import adxl_pkg::*;

  localparam int last_idx = burst_len - 1;
  localparam int idx_w    = $clog2(last_idx);

  logic [7:0]  stage [last_idx];  // all bytes but the last
  logic [15:0] seq;               // next sequence number
  logic        publish;

  assign publish = rx_byte.strobe && (rx_byte.index == 4'(last_idx));

  // 3 bytes MSB first, low nibble of the last byte is reserved
  function automatic axis_t to_axis(input logic [7:0] b_hi, input logic [7:0] b_mid,
                                    input logic [7:0] b_lo);
    return axis_t'({b_hi, b_mid, b_lo[7:4]});
  endfunction

  always_ff @(posedge clk)
  begin
    if (rx_byte.strobe && rx_byte.index < 4'(last_idx))
      stage[rx_byte.index[idx_w-1:0]] <= rx_byte.data;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sample_valid <= 1'b0;
      seq          <= '0;
    end
    else
    begin
      sample_valid <= publish;  // one cycle after last byte strobe
      if (publish)
        seq <= seq + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (publish)
    begin
      sample.x   <= to_axis(stage[0], stage[1], stage[2]);
      sample.y   <= to_axis(stage[3], stage[4], stage[5]);
      sample.z   <= to_axis(stage[6], stage[7], rx_byte.data);  // last byte bypasses stage
      sample.seq <= seq;
    end
  end

endmodule

/* src/sync_nco.sv */
// phase-accumulator SYNC/DRDY generator locked to PPS
// increment trimmed once per valid PPS interval, scaled by the tick error
// faster/slower move the increment by one LSB per cycle held, synchronous to clk
// needs pa_bits of 8 or more and sync_hz/pps_hz below 4096
module sync_nco #(
  parameter int clk_hz  = 40_000_000,
  parameter int pps_hz  = 10,
  parameter int sync_hz = 1000,
  parameter int pa_bits = 30
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sync_pkg::pps_event_t   pps_event,
  input  logic                   faster,
  input  logic                   slower,
  output logic                   sync_tick,
  output logic                   drdy,
  output sync_pkg::sync_status_t status
);
  import sync_pkg::*;

  localparam longint inc_nom_l = (longint'(sync_hz) << pa_bits) / longint'(clk_hz);
  // increment change worth one tick per pps interval
  localparam longint step_l    = (longint'(pps_hz) << pa_bits) / longint'(clk_hz);
  localparam logic [pa_bits-1:0] inc_nom   = pa_bits'(inc_nom_l);
  localparam int                 step      = (step_l > 0) ? int'(step_l) : 1;
  localparam logic [count_w-1:0] count_nom = count_w'(sync_hz / pps_hz);

  logic [pa_bits-1:0]      acc;
  logic [pa_bits-1:0]      inc;
  logic [pa_bits-1:0]      nudge;       // +1, -1 or 0
  logic [pa_bits-1:0]      trim;
  logic signed [count_w:0] err;         // nominal minus counted
  logic                    trim_en;
  logic [count_w-1:0]      tick_cnt;    // ticks in current interval
  logic [count_w-1:0]      count_prev;
  logic [1:0]              match_cnt;   // clean intervals in a row
  logic                    locked;
  logic                    pps_ok;

  assign err     = $signed({1'b0, count_nom}) - $signed({1'b0, tick_cnt});
  assign trim_en = pps_event.strobe & pps_event.valid;
  assign trim    = trim_en ? pa_bits'(err * step) : '0;  // zero on a match
  assign nudge   = pa_bits'(faster) - pa_bits'(slower);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      acc        <= '0;
      inc        <= inc_nom;
      drdy       <= 1'b0;
      sync_tick  <= 1'b0;
      tick_cnt   <= '0;
      count_prev <= '0;
      match_cnt  <= '0;
      locked     <= 1'b0;
      pps_ok     <= 1'b0;
    end
    else
    begin
      acc       <= acc + inc;
      inc       <= inc + nudge + trim;
      drdy      <= acc[pa_bits-1];                // registered MSB
      sync_tick <= acc[pa_bits-1] & ~drdy;        // aligned with drdy rise
      if (pps_event.strobe)
      begin
        tick_cnt <= count_w'(sync_tick);          // coincident tick opens new interval
        pps_ok   <= pps_event.valid;
        if (pps_event.valid && err == '0)
        begin
          count_prev <= tick_cnt;
          locked     <= (match_cnt != 2'd0);      // second match sets lock
          if (match_cnt != 2'd2)
            match_cnt <= match_cnt + 1'b1;
        end
        else
        begin
          if (pps_event.valid)
            count_prev <= tick_cnt;
          match_cnt <= '0;
          locked    <= 1'b0;
        end
      end
      else if (sync_tick && tick_cnt != '1)
        tick_cnt <= tick_cnt + 1'b1;
    end
  end

  assign status = '{locked: locked, pps_ok: pps_ok, count_prev: count_prev,
                    phase_hi: acc[pa_bits-1 -: 8]};

endmodule

/* src/sync_pkg.sv */
// PPS event and NCO status types shared by the decoder, the NCO and the top
// interval field holds up to 2^22-1 clocks, so clk_hz/pps_hz must stay below that
// count field holds up to 4095 sync ticks per PPS interval
package sync_pkg;

  localparam int interval_w = 22;  // clocks between pps edges
  localparam int count_w    = 12;  // sync ticks per pps interval

  // one record per detected pps rising edge
  typedef struct packed {
    logic                  strobe;    // single cycle
    logic                  valid;     // interval inside tolerance
    logic [interval_w-1:0] interval;  // clocks since previous edge
  } pps_event_t;

  // NCO state, for monitoring only
  typedef struct packed {
    logic               locked;      // two clean intervals in a row
    logic               pps_ok;      // last pps verdict
    logic [count_w-1:0] count_prev;  // ticks in last valid interval
    logic [7:0]         phase_hi;    // accumulator top byte
  } sync_status_t;

endpackage

/* testbench/adxl_logger_tb.sv */
// directed tests for adxl_logger_top with a scaled-down clock plan
// 128 clocks per sync tick, 16384 clocks per PPS interval, SCLK = clk/4
// inputs move 5 units after the rising edge, outputs are read at that point too
// stops at the first error
module adxl_logger_tb;
  import sync_pkg::*;
  import adxl_pkg::*;

  localparam int pps_period = 16384;        // nominal clocks per pulse
  localparam int pps_high   = 32;           // pulse width
  localparam int burst_cyc  = 160 * 2 + 1;  // csn low time at sclk_div 2
  localparam int nudge_cyc  = 2000;
  localparam int wait_max   = 2000;         // clocks allowed for any handshake

  logic         clk;
  logic         rst_n;
  logic         pps;
  logic         faster;
  logic         slower;
  logic         adxl_miso;
  logic         adxl_csn;
  logic         adxl_sclk;
  logic         adxl_mosi;
  logic         drdy;
  sync_status_t status;
  sample_t      sample;
  logic         sample_valid;

  tb_clock_gen #(
    .period      (40),
    .reset_cycles(10)
  ) clock_gen_i (
    .clk  (clk),
    .rst_n(rst_n)
  );

  adxl_logger_top #(
    .clk_hz  (131072),
    .pps_hz  (8),
    .pps_tol (64),
    .sync_hz (1024),
    .pa_bits (16),
    .sclk_div(2)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pps         (pps),
    .faster      (faster),
    .slower      (slower),
    .adxl_miso   (adxl_miso),
    .adxl_csn    (adxl_csn),
    .adxl_sclk   (adxl_sclk),
    .adxl_mosi   (adxl_mosi),
    .drdy        (drdy),
    .status      (status),
    .sample      (sample),
    .sample_valid(sample_valid)
  );

  adxl_spi_model #(
    .seed(32'h2900_f85b)
  ) spi_model_i (
    .csn (adxl_csn),
    .sclk(adxl_sclk),
    .mosi(adxl_mosi),
    .miso(adxl_miso)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act));
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp)
      fail_run($sformatf("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act));
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp)
      fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  // phase_hi free running once out of reset, compared only on request
  task automatic check_status(input string name, input sync_status_t exp,
                              input sync_status_t act, input logic with_phase);
    sync_status_t cmp;
    cmp = act;
    if (!with_phase)
      cmp.phase_hi = exp.phase_hi;
    if (cmp !== exp)
      fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  // axis k = bytes 3k, 3k+1 and top nibble of 3k+2, so each axis is one contiguous slice
  function automatic sample_t expect_sample(input logic [71:0] frame, input logic [15:0] seq);
    sample_t s;
    s.x   = frame[71:52];
    s.y   = frame[47:28];
    s.z   = frame[23:4];
    s.seq = seq;
    return s;
  endfunction

  function automatic sync_status_t status_of(input logic locked, input logic pps_ok,
                                             input logic [count_w-1:0] count);
    sync_status_t s;
    s            = '0;
    s.locked     = locked;
    s.pps_ok     = pps_ok;
    s.count_prev = count;
    return s;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_csn(input logic level);
    int n;
    n = 0;
    while (adxl_csn !== level)
    begin
      if (n == wait_max)
        fail_run($sformatf("csn did not reach %b within %0d clocks", level, wait_max));
      next_cycle();
      n++;
    end
  endtask

  // current cycle counts, so a strobe seen on entry is not missed
  task automatic catch_sample();
    int n;
    n = 0;
    while (sample_valid !== 1'b1)
    begin
      if (n == wait_max)
        fail_run("no sample_valid within the wait limit");
      next_cycle();
      n++;
    end
  endtask

  // rise comes gap clocks after the previous rise when called back to back
  task automatic pps_pulse(input int gap);
    repeat (gap - pps_high) next_cycle();
    pps = 1'b1;
    repeat (pps_high) next_cycle();
    pps = 1'b0;  // status settled 4 clocks after the rise
  endtask

  task automatic relock();
    int n;
    n = 0;
    while (status.locked !== 1'b1)
    begin
      if (n == 6)
        fail_run("status.locked not set within six PPS intervals");
      pps_pulse(pps_period);
      n++;
    end
  endtask

  task automatic reset_values();
    int n;
    next_cycle();  // reset applied on the first edge
    check_bit("adxl_csn", 1'b1, adxl_csn);
    check_bit("adxl_sclk", 1'b0, adxl_sclk);
    check_bit("adxl_mosi", 1'b0, adxl_mosi);
    check_bit("sample_valid", 1'b0, sample_valid);
    check_bit("drdy", 1'b0, drdy);
    check_status("status", '0, status, 1'b1);
    n = 0;
    while (rst_n !== 1'b1)
    begin
      if (n == 20)
        fail_run("rst_n never released");
      @(posedge clk);  // rst_n stable at the edge
      n++;
    end
    #5;  // first edge out of reset has passed
    check_bit("adxl_csn", 1'b1, adxl_csn);
    check_bit("adxl_sclk", 1'b0, adxl_sclk);
    check_bit("sample_valid", 1'b0, sample_valid);
    check_status("status", status_of(1'b0, 1'b0, 12'd0), status, 1'b0);
  endtask

  task automatic command_frame();
    int n;
    wait_csn(1'b0);
    check_bit("drdy", 1'b1, drdy);  // drdy rose with the tick, csn one cycle later
    n = 0;
    while (adxl_csn === 1'b0 && n <= burst_cyc)
    begin
      next_cycle();
      n++;
    end
    check_cycles("csn low cycles", burst_cyc, n);
    if (spi_model_i.cmd_q.size() == 0)
      fail_run("no command byte captured in the first frame");
    check_byte("command byte", 8'h11, spi_model_i.cmd_q.pop_front());  // read of 8'h08
  endtask

  // first frame already consumed its command byte
  task automatic sample_frames(input int frames);
    logic [71:0] frame;
    int          f;
    for (f = 0; f < frames; f++)
    begin
      catch_sample();
      if (spi_model_i.frame_q.size() == 0)
        fail_run("sample_valid without a served frame");
      frame = spi_model_i.frame_q.pop_front();
      check_sample("sample", expect_sample(frame, 16'(f)), sample);
      if (f > 0)
      begin
        if (spi_model_i.cmd_q.size() == 0)
          fail_run("frame ended without a command byte");
        check_byte("command byte", 8'h11, spi_model_i.cmd_q.pop_front());
      end
      next_cycle();
    end
  endtask

  task automatic pps_lock();
    relock();  // first edge has no reference
    check_status("status", status_of(1'b1, 1'b1, 12'd128), status, 1'b0);
  endtask

  task automatic pps_reject();
    pps_pulse(8000);  // far outside 16384 +- 64
    check_status("status", status_of(1'b0, 1'b0, 12'd128), status, 1'b0);
    relock();
    check_status("status", status_of(1'b1, 1'b1, 12'd128), status, 1'b0);
  endtask

  task automatic rate_nudge();
    faster = 1'b1;  // +1 LSB of increment per clock
    repeat (nudge_cyc) next_cycle();
    faster = 1'b0;
    pps_pulse(pps_period - nudge_cyc);  // keeps the nominal spacing
    check_bit("status.locked", 1'b0, status.locked);
    check_bit("status.pps_ok", 1'b1, status.pps_ok);
    check_bit("status.count_prev > 128", 1'b1, status.count_prev > 12'd128);
    relock();
    check_status("status", status_of(1'b1, 1'b1, 12'd128), status, 1'b0);
  endtask

  initial
  begin
    pps    = 1'b0;
    faster = 1'b0;
    slower = 1'b0;
    reset_values();
    command_frame();
    sample_frames(4);
    pps_lock();
    pps_reject();
    rate_nudge();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* testbench/adxl_spi_model.sv */
// behavioral ADXL355 SPI slave, mode 0, burst reads only
// every csn fall opens a frame of 9 fresh random data bytes
// command bits taken on SCLK rise, miso moves 5 units after SCLK fall
// frame_q and cmd_q are read by the testbench through hierarchical names
module adxl_spi_model #(
  parameter logic [31:0] seed = 32'h0
) (
  input  logic csn,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  logic [71:0] frame_q [$];  // XDATA3 in bits 71:64, ZDATA1 in 7:0
  logic [7:0]  cmd_q [$];    // command byte per frame

  initial
  begin
    logic [71:0] frame;
    logic [7:0]  cmd;
    int          b;
    miso = 1'b0;
    void'($urandom(seed));  // one seed for the run
    forever
    begin
      @(negedge csn);
      frame = '0;
      cmd   = '0;
      for (b = 0; b < 9; b++)
        frame = {frame[63:0], 8'($urandom)};
      frame_q.push_back(frame);
      #5 miso = 1'b0;  // don't care during command
      for (b = 0; b < 80; b++)
      begin
        @(posedge sclk);
        if (b < 8)
          cmd = {cmd[6:0], mosi};  // MSB first
        if (b == 7)
          cmd_q.push_back(cmd);
        @(negedge sclk);
        #5;
        if (b >= 7 && b < 79)
          miso = frame[71 - (b - 7)];  // next bit, data from the 9th clock
      end
    end
  end

endmodule

/* testbench/tb_clock_gen.sv */
// clock and reset source for the testbench
// rst_n is released 5 units after the last reset edge, like every other input
module tb_clock_gen #(
  parameter int period       = 40,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;  // 50% duty
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #5 rst_n = 1'b1;
  end

endmodule
